//--- bench/chromatic_adapt_checker.sv
module chromatic_adapt_checker
    import fixed_point_pkg::*;
    import bradford_pkg::*;
#(
    parameter logic signed [q_width-1:0] cone_clamp = 2 * fp_one
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 busy,
    input logic                 matrix_valid,
    input logic [mat_width-1:0] comp_matrix
);

    int failures = 0;

    // ----------------------------------------------------------
    // Output handshake
    // ----------------------------------------------------------
    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        matrix_valid |=> !matrix_valid)
        else begin
            $error("matrix_valid lasted more than one cycle");
            failures++;
        end

    valid_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        matrix_valid |-> $past(busy))
        else begin
            $error("matrix_valid without busy in the cycle before");
            failures++;
        end

    // Every element stays inside the clamp range
    for (genvar e = 0; e < 9; e++) begin : g_elem
        elem_clamped: assert property (@(posedge clk) disable iff (!rst_n)
            matrix_valid |-> ($signed(comp_matrix[e*q_width +: q_width]) <= cone_clamp
                          && $signed(comp_matrix[e*q_width +: q_width]) >= -cone_clamp))
            else begin
                $error("comp_matrix element %0d outside the clamp range", e);
                failures++;
            end
    end

endmodule

bind chromatic_adapt_top chromatic_adapt_checker #(
    .cone_clamp (cone_clamp)
) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .busy         (busy),
    .matrix_valid (matrix_valid),
    .comp_matrix  (comp_matrix)
);

//--- bench/chromatic_adapt_tb.sv
module chromatic_adapt_tb
    import fixed_point_pkg::*;
    import bradford_pkg::*;
();

    localparam logic signed [q_width-1:0] clamp = 2 * fp_one;
    localparam int n_tests     = 9;
    localparam int cycle_limit = 400 * n_tests;

    logic                 clk;
    logic                 rst_n;
    logic                 xyz_valid;
    logic [vec_width-1:0] ambient_xyz;
    logic [vec_width-1:0] ref_xyz;
    logic [mat_width-1:0] comp_matrix;
    logic                 matrix_valid;
    logic                 busy;

    logic [vec_width-1:0] amb_tab [n_tests];
    logic [vec_width-1:0] ref_tab [n_tests];
    logic                 dup_tab [n_tests];
    string                name_tab [n_tests];
    string                cur_name = "reset";
    int                   pass_count = 0;
    int                   fail_count = 0;
    int                   valid_count = 0;
    int                   cycles = 0;

    chromatic_adapt_top #(
        .cone_clamp (clamp)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .xyz_valid    (xyz_valid),
        .ambient_xyz  (ambient_xyz),
        .ref_xyz      (ref_xyz),
        .comp_matrix  (comp_matrix),
        .matrix_valid (matrix_valid),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (matrix_valid)
            valid_count <= valid_count + 1;
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("ERROR: result never arrived for test %s within %0d cycles", cur_name,
                 cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [vec_width-1:0] cone_response(input logic [vec_width-1:0] v);
        logic [vec_width-1:0]        lms;
        logic signed [2*q_width-1:0] acc;
        for (int r = 0; r < 3; r++) begin
            acc = '0;
            for (int c = 0; c < 3; c++)
                acc = acc + fp_mul(brad_fwd[3*r+c], v[c*q_width +: q_width]);
            lms[r*q_width +: q_width] = fp_sat(acc, clamp);
        end
        return lms;
    endfunction

    // Gain per channel is num / den in Q16.16 and saturates for tiny divisors
    function automatic logic [vec_width-1:0] divide_gains(
        input logic [vec_width-1:0] num,
        input logic [vec_width-1:0] den
    );
        logic [vec_width-1:0]        g;
        logic signed [q_width-1:0]   n;
        logic signed [q_width-1:0]   d;
        logic [63:0]                 n_mag;
        logic [63:0]                 d_mag;
        logic signed [63:0]          quo;
        for (int ch = 0; ch < 3; ch++) begin
            n = num[ch*q_width +: q_width];
            d = den[ch*q_width +: q_width];
            n_mag = (n < 0) ? -64'(n) : 64'(n);
            d_mag = (d < 0) ? -64'(d) : 64'(d);
            if (d_mag < 64'(small_divisor)) begin
                if (n == 0)
                    g[ch*q_width +: q_width] = '0;
                else
                    g[ch*q_width +: q_width] = ((n < 0) == (d < 0)) ? fp_max : fp_min;
            end else begin
                quo = (n_mag << frac_bits) / d_mag;
                if ((n < 0) != (d < 0))
                    quo = -quo;
                g[ch*q_width +: q_width] = fp_sat(quo, fp_max);
            end
        end
        return g;
    endfunction

    // inv * diag(g) * fwd with the clamp on each element
    function automatic logic [mat_width-1:0] build_matrix(input logic [vec_width-1:0] g);
        logic [mat_width-1:0]        m;
        logic signed [2*q_width-1:0] acc;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                acc = '0;
                for (int k = 0; k < 3; k++)
                    acc = acc + fp_mul(brad_inv[3*r+k],
                                       fp_mul(g[k*q_width +: q_width], brad_fwd[3*k+c]));
                m[(3*r+c)*q_width +: q_width] = fp_sat(acc, clamp);
            end
        end
        return m;
    endfunction

    // ----------------------------------------------------------
    // Stimulus table with vectors as {Z, Y, X}
    // ----------------------------------------------------------
    task automatic fill_table();
        logic [31:0] seed;
        seed = 32'hf698_f34e;
        amb_tab[0] = d65_white;
        name_tab[0] = "d65_same";
        amb_tab[1] = {32'h0000_5b19, 32'h0001_0000, 32'h0001_1937};
        name_tab[1] = "warm_a";
        amb_tab[2] = {32'h0001_39f4, 32'h0001_0000, 32'h0000_f321};
        name_tab[2] = "cool_d75";
        // S cone response of -1 LSB is far below the small divisor limit
        amb_tab[3] = {32'h0000_0000, 32'h0000_9f50, 32'h0001_1890};
        name_tab[3] = "tiny_s";
        amb_tab[4] = amb_tab[1];
        name_tab[4] = "busy_ignored";
        for (int i = 5; i < n_tests; i++) begin
            for (int c = 0; c < 3; c++) begin
                seed = lcg_next(seed);
                amb_tab[i][c*q_width +: q_width] = 32'h4000 + seed % 32'h1_0001;
            end
            name_tab[i] = $sformatf("random_%0d", i - 4);
        end
        for (int i = 0; i < n_tests; i++) begin
            ref_tab[i] = d65_white;
            dup_tab[i] = (i == 4);
        end
    endtask

    task automatic run_test(input int i);
        logic [mat_width-1:0]      expected;
        logic signed [q_width-1:0] got;
        logic signed [q_width-1:0] want;
        int                        errors;
        errors = 0;
        cur_name = name_tab[i];
        expected = build_matrix(divide_gains(cone_response(ref_tab[i]),
                                             cone_response(amb_tab[i])));
        @(posedge clk);
        xyz_valid   <= 1'b1;
        ambient_xyz <= amb_tab[i];
        ref_xyz     <= ref_tab[i];
        @(posedge clk);
        xyz_valid <= 1'b0;
        if (dup_tab[i]) begin
            // Second request lands while the first is in flight
            repeat (3) @(posedge clk);
            xyz_valid   <= 1'b1;
            ambient_xyz <= amb_tab[2];
            @(posedge clk);
            xyz_valid <= 1'b0;
        end
        @(negedge clk);
        while (!matrix_valid)
            @(negedge clk);
        for (int e = 0; e < 9; e++) begin
            got  = comp_matrix[e*q_width +: q_width];
            want = expected[e*q_width +: q_width];
            if (got !== want) begin
                $display("FAIL t=%0t %s element %0d got %h expected %h", $time, cur_name, e,
                         got, want);
                errors++;
            end
            // Equal white points give a matrix close to identity
            if (i == 0 && (e % 4) == 0
                    && (got - fp_one > 32'sh200 || fp_one - got > 32'sh200)) begin
                $display("FAIL t=%0t %s element %0d is %h, not near 1.0", $time, cur_name, e,
                         got);
                errors++;
            end
        end
        if (dup_tab[i]) begin
            repeat (4) @(negedge clk);
            if (busy) begin
                $display("ERROR: request issued while busy was accepted in test %s", cur_name);
                errors++;
            end
        end
        if (errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("test %s %s", cur_name, (errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n       = 1'b0;
        xyz_valid   = 1'b0;
        ambient_xyz = '0;
        ref_xyz     = '0;
        fill_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || matrix_valid !== 1'b0 || comp_matrix !== '0) begin
            $display("FAIL t=%0t reset outputs are not zero", $time);
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("test %s %s", "reset", (fail_count == 0) ? "ok" : "mismatch");
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        @(negedge clk);
        if (valid_count != n_tests) begin
            $display("ERROR: saw %0d matrix_valid pulses for %0d requests", valid_count,
                     n_tests);
            fail_count++;
        end
        if (dut.u_checker.failures != 0) begin
            $display("ERROR: %0d assertion failures in the checker", dut.u_checker.failures);
            fail_count++;
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- design/adapt_matrix_builder.sv
module adapt_matrix_builder
    import fixed_point_pkg::*;
    import bradford_pkg::*;
#(
    parameter logic signed [q_width-1:0] cone_clamp = 2 * fp_one
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 gains_valid,
    input  logic [vec_width-1:0] gains,
    output logic [mat_width-1:0] comp_matrix,
    output logic                 matrix_done
);

    logic                   active;
    logic [1:0]             row;
    logic [vec_width-1:0]   gains_q;
    logic [2*vec_width-1:0] rows_q;
    logic [vec_width-1:0]   row_val;

    // Row r of inv * diag(g) * fwd, each element a clamped sum of three products
    function automatic logic [vec_width-1:0] build_row(
        input logic [1:0]           r,
        input logic [vec_width-1:0] g
    );
        logic [vec_width-1:0]        out;
        logic signed [2*q_width-1:0] acc;
        logic signed [q_width-1:0]   scaled;
        for (int c = 0; c < 3; c++) begin
            acc = '0;
            for (int k = 0; k < 3; k++) begin
                scaled = fp_mul(g[k*q_width +: q_width], brad_fwd[3*k+c]);
                acc    = acc + fp_mul(brad_inv[3*r+k], scaled);
            end
            out[c*q_width +: q_width] = fp_sat(acc, cone_clamp);
        end
        return out;
    endfunction

    assign row_val = build_row(row, gains_q);

    // Row 2 goes straight into the output together with the staged rows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            row         <= 2'd0;
            matrix_done <= 1'b0;
            comp_matrix <= '0;
        end else begin
            matrix_done <= 1'b0;
            if (gains_valid) begin
                active <= 1'b1;
                row    <= 2'd0;
            end else if (active) begin
                row <= row + 1'b1;
                if (row == 2'd2) begin
                    active      <= 1'b0;
                    matrix_done <= 1'b1;
                    comp_matrix <= {row_val, rows_q};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gains_valid)
            gains_q <= gains;
        if (active && row != 2'd2)
            rows_q[row*vec_width +: vec_width] <= row_val;
    end

endmodule

//--- design/adapt_sequencer.sv
module adapt_sequencer
    import bradford_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 xyz_valid,
    input  logic [vec_width-1:0] ambient_xyz,
    input  logic [vec_width-1:0] ref_xyz,
    input  logic                 lms_valid,
    input  logic [vec_width-1:0] lms_out,
    input  logic                 matrix_done,
    output logic                 busy,
    output logic [vec_width-1:0] vec_in,
    output logic                 load,
    output logic                 start,
    output logic [vec_width-1:0] lms_amb,
    output logic [vec_width-1:0] lms_ref,
    output logic                 matrix_valid
);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_feed    = 2'd1;
    localparam logic [1:0] st_collect = 2'd2;
    localparam logic [1:0] st_build   = 2'd3;

    logic [1:0]           state;
    logic                 got_amb;
    logic [vec_width-1:0] ref_q;

    assign busy = (state != st_idle);

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            load         <= 1'b0;
            start        <= 1'b0;
            got_amb      <= 1'b0;
            matrix_valid <= 1'b0;
        end else begin
            load         <= 1'b0;
            start        <= 1'b0;
            matrix_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (xyz_valid) begin
                        load  <= 1'b1;
                        state <= st_feed;
                    end
                end
                st_feed: begin
                    load  <= 1'b1;
                    state <= st_collect;
                end
                st_collect: begin
                    // Ambient response comes back first
                    if (lms_valid) begin
                        got_amb <= !got_amb;
                        if (got_amb) begin
                            start <= 1'b1;
                            state <= st_build;
                        end
                    end
                end
                default: begin
                    if (matrix_done) begin
                        matrix_valid <= 1'b1;
                        state        <= st_idle;
                    end
                end
            endcase
        end
    end

    // Vector and response registers
    always_ff @(posedge clk) begin
        if (state == st_idle && xyz_valid) begin
            vec_in <= ambient_xyz;
            ref_q  <= ref_xyz;
        end
        if (state == st_feed)
            vec_in <= ref_q;
        if (state == st_collect && lms_valid) begin
            if (got_amb)
                lms_ref <= lms_out;
            else
                lms_amb <= lms_out;
        end
    end

endmodule

//--- design/bradford_pkg.sv
package bradford_pkg;

    import fixed_point_pkg::*;

    // Component 0 (X or L) sits in the lowest word
    localparam int vec_width = 3 * q_width;
    // Row-major, element (r,c) is word 3r+c
    localparam int mat_width = 9 * q_width;

    // ----------------------------------------------------------
    // Bradford forward matrix, XYZ to LMS
    // ----------------------------------------------------------
    localparam logic signed [q_width-1:0] brad_fwd [9] = '{
        32'sh0000_e525, 32'sh0000_4433, 32'shffff_d6ae,  //  0.8951  0.2664 -0.1614
        32'shffff_3ff3, 32'sh0001_b6a8, 32'sh0000_0965,  // -0.7502  1.7135  0.0367
        32'sh0000_09f5, 32'shffff_ee77, 32'sh0001_0794   //  0.0389 -0.0685  1.0296
    };

    // ----------------------------------------------------------
    // Inverse Bradford matrix, LMS back to XYZ
    // ----------------------------------------------------------
    localparam logic signed [q_width-1:0] brad_inv [9] = '{
        32'sh0000_fcac, 32'shffff_da5b, 32'sh0000_28f3,  //  0.9870 -0.1471  0.1600
        32'sh0000_6eac, 32'sh0000_84b3, 32'sh0000_0c9e,  //  0.4323  0.5184  0.0493
        32'shffff_fdd1, 32'sh0000_0a40, 32'sh0000_f7ef   // -0.0085  0.0400  0.9685
    };

    // D65 white point, {Z, Y, X}
    localparam logic [vec_width-1:0] d65_white = {
        32'h0001_16be,  // Z = 1.08883
        32'h0001_0000,  // Y = 1.0
        32'h0000_f352   // X = 0.95047
    };

endpackage

//--- design/chromatic_adapt_top.sv
module chromatic_adapt_top
    import fixed_point_pkg::*;
    import bradford_pkg::*;
#(
    parameter logic signed [q_width-1:0] cone_clamp = 2 * fp_one
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 xyz_valid,
    input  logic [vec_width-1:0] ambient_xyz,
    // Usually d65_white
    input  logic [vec_width-1:0] ref_xyz,
    output logic [mat_width-1:0] comp_matrix,
    output logic                 matrix_valid,
    output logic                 busy
);

    logic [vec_width-1:0] vec_in;
    logic                 load;
    logic [vec_width-1:0] lms_out;
    logic                 lms_valid;
    logic                 start;
    logic [vec_width-1:0] lms_amb;
    logic [vec_width-1:0] lms_ref;
    logic [vec_width-1:0] gains;
    logic                 gains_valid;
    logic                 matrix_done;

    adapt_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .xyz_valid    (xyz_valid),
        .ambient_xyz  (ambient_xyz),
        .ref_xyz      (ref_xyz),
        .lms_valid    (lms_valid),
        .lms_out      (lms_out),
        .matrix_done  (matrix_done),
        .busy         (busy),
        .vec_in       (vec_in),
        .load         (load),
        .start        (start),
        .lms_amb      (lms_amb),
        .lms_ref      (lms_ref),
        .matrix_valid (matrix_valid)
    );

    cone_transform #(
        .cone_clamp (cone_clamp)
    ) u_cone (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .vec_in    (vec_in),
        .lms_out   (lms_out),
        .lms_valid (lms_valid)
    );

    gain_divider u_divider (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .lms_ref     (lms_ref),
        .lms_amb     (lms_amb),
        .gains       (gains),
        .gains_valid (gains_valid)
    );

    adapt_matrix_builder #(
        .cone_clamp (cone_clamp)
    ) u_builder (
        .clk         (clk),
        .rst_n       (rst_n),
        .gains_valid (gains_valid),
        .gains       (gains),
        .comp_matrix (comp_matrix),
        .matrix_done (matrix_done)
    );

endmodule

//--- design/cone_transform.sv
module cone_transform
    import fixed_point_pkg::*;
    import bradford_pkg::*;
#(
    parameter logic signed [q_width-1:0] cone_clamp = 2 * fp_one
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic [vec_width-1:0] vec_in,
    output logic [vec_width-1:0] lms_out,
    output logic                 lms_valid
);

    logic [vec_width-1:0] lms_next;

    // One dot product per cone channel
    for (genvar r = 0; r < 3; r++) begin : g_row
        logic signed [2*q_width-1:0] acc;

        assign acc = fp_mul(brad_fwd[3*r],   vec_in[0         +: q_width])
                   + fp_mul(brad_fwd[3*r+1], vec_in[q_width   +: q_width])
                   + fp_mul(brad_fwd[3*r+2], vec_in[2*q_width +: q_width]);

        assign lms_next[r*q_width +: q_width] = fp_sat(acc, cone_clamp);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lms_valid <= 1'b0;
        end else begin
            lms_valid <= load;
        end
    end

    // Result register, a new vector may enter every cycle
    always_ff @(posedge clk) begin
        if (load) begin
            lms_out <= lms_next;
        end
    end

endmodule

//--- design/fixed_point_pkg.sv
package fixed_point_pkg;

    // ----------------------------------------------------------
    // Q16.16 signed word format
    // ----------------------------------------------------------
    localparam int q_width   = 32;
    localparam int frac_bits = 16;

    localparam logic signed [q_width-1:0] fp_one = 32'sh0001_0000;
    localparam logic signed [q_width-1:0] fp_max = 32'sh7fff_ffff;
    localparam logic signed [q_width-1:0] fp_min = 32'sh8000_0000;

    // Divisors below this magnitude take the saturating path
    localparam logic signed [q_width-1:0] small_divisor = 32'sh0000_0080;

    // Full 64-bit product, rescaled back to Q16.16
    function automatic logic signed [q_width-1:0] fp_mul(
        input logic signed [q_width-1:0] a,
        input logic signed [q_width-1:0] b
    );
        logic signed [2*q_width-1:0] prod;
        prod = a * b;
        prod = prod >>> frac_bits;
        return prod[q_width-1:0];
    endfunction

    // Clamp a wide signed value into [-limit, +limit]
    function automatic logic signed [q_width-1:0] fp_sat(
        input logic signed [2*q_width-1:0] value,
        input logic signed [q_width-1:0]   limit
    );
        if (value > limit)
            return limit;
        else if (value < -limit)
            return -limit;
        else
            return value[q_width-1:0];
    endfunction

endpackage

//--- design/gain_divider.sv
module gain_divider
    import fixed_point_pkg::*;
    import bradford_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [vec_width-1:0] lms_ref,
    input  logic [vec_width-1:0] lms_amb,
    output logic [vec_width-1:0] gains,
    output logic                 gains_valid
);

    // Dividend is |ref| shifted up by frac_bits, one quotient bit per step
    localparam int div_steps = q_width + frac_bits;
    localparam int cnt_width = $clog2(div_steps + 1);
    localparam logic [cnt_width-1:0] steps = cnt_width'(div_steps);

    logic                        running;
    logic [1:0]                  chan;
    logic [cnt_width-1:0]        count;
    logic [vec_width-1:0]        ref_q;
    logic [vec_width-1:0]        amb_q;
    logic [q_width-1:0]          rem_q;
    logic [div_steps-1:0]        quo_q;

    logic signed [q_width-1:0]   cur_ref;
    logic signed [q_width-1:0]   cur_amb;
    logic [q_width-1:0]          ref_mag;
    logic [q_width-1:0]          amb_mag;
    logic [q_width:0]            rem_shift;
    logic [q_width:0]            rem_diff;
    logic [q_width-1:0]          rem_next;
    logic [div_steps-1:0]        quo_next;
    logic signed [2*q_width-1:0] quo_signed;
    logic signed [q_width-1:0]   result;

    assign cur_ref = ref_q[chan*q_width +: q_width];
    assign cur_amb = amb_q[chan*q_width +: q_width];
    assign ref_mag = cur_ref[q_width-1] ? -cur_ref : cur_ref;
    assign amb_mag = cur_amb[q_width-1] ? -cur_amb : cur_amb;

    // ----------------------------------------------------------
    // Restoring step and per-channel result
    // ----------------------------------------------------------
    assign rem_shift = {rem_q, quo_q[div_steps-1]};
    assign rem_diff  = rem_shift - {1'b0, amb_mag};

    always_comb begin
        if (rem_shift >= {1'b0, amb_mag}) begin
            rem_next = rem_diff[q_width-1:0];
            quo_next = {quo_q[div_steps-2:0], 1'b1};
        end else begin
            rem_next = rem_shift[q_width-1:0];
            quo_next = {quo_q[div_steps-2:0], 1'b0};
        end

        quo_signed = {{(2*q_width-div_steps){1'b0}}, quo_next};
        if (cur_ref[q_width-1] ^ cur_amb[q_width-1])
            quo_signed = -quo_signed;

        // Tiny divisor overrides the loop result
        if (amb_mag < small_divisor) begin
            if (cur_ref == '0)
                result = '0;
            else if (cur_ref[q_width-1] == cur_amb[q_width-1])
                result = fp_max;
            else
                result = fp_min;
        end else begin
            result = fp_sat(quo_signed, fp_max);
        end
    end

    // Count 0 is the setup cycle of a channel, then div_steps iterations
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            chan        <= 2'd0;
            count       <= '0;
            gains_valid <= 1'b0;
        end else begin
            gains_valid <= 1'b0;
            if (!running) begin
                if (start) begin
                    running <= 1'b1;
                    chan    <= 2'd0;
                    count   <= '0;
                end
            end else if (count == '0) begin
                count <= steps;
            end else begin
                count <= count - 1'b1;
                if (count == cnt_width'(1)) begin
                    if (chan == 2'd2) begin
                        running     <= 1'b0;
                        gains_valid <= 1'b1;
                    end else begin
                        chan <= chan + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running) begin
            ref_q <= lms_ref;
            amb_q <= lms_amb;
        end
        if (running) begin
            if (count == '0) begin
                rem_q <= '0;
                quo_q <= {ref_mag, {frac_bits{1'b0}}};
            end else begin
                rem_q <= rem_next;
                quo_q <= quo_next;
                if (count == cnt_width'(1))
                    gains[chan*q_width +: q_width] <= result;
            end
        end
    end

endmodule

//--- vlog.f
design/fixed_point_pkg.sv
design/bradford_pkg.sv
design/cone_transform.sv
design/gain_divider.sv
design/adapt_matrix_builder.sv
design/adapt_sequencer.sv
design/chromatic_adapt_top.sv
bench/chromatic_adapt_checker.sv
bench/chromatic_adapt_tb.sv
